// ==== build.f ====
+incdir+.
rvviPkg.sv
retireFilter.sv
writebackDecode.sv
netEventTracker.sv
rvviTracer.sv
tbRvviTracer.sv

// ==== Makefile ====
TOP := tbRvviTracer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		-f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only -Wall -Wno-fatal --timescale 1ns/1ns --top-module rvviTracer \
		rvviPkg.sv retireFilter.sv writebackDecode.sv netEventTracker.sv rvviTracer.sv

clean:
	rm -rf obj_dir

// ==== tbRvviModel.svh ====
// Reference model state for the trace converter and the function that
// predicts one output trace record from an accepted retirement
`ifndef TB_RVVI_MODEL_SVH
`define TB_RVVI_MODEL_SVH

// Model state, cleared while reset is high
orderT              mdlLastOrder;
logic               mdlSeen;
xlenT [NumCsrs-1:0] mdlCsr;
netStateT           mdlNets;

task automatic clearModel();
   mdlLastOrder = '0;
   mdlSeen      = 1'b0;
   mdlCsr       = '0;
   mdlNets      = '0;
endtask

// Returns 0 for a replayed order, else 1 with the expected trace in want
function automatic logic predictTrace(input rvfiRetireT rec, output rvviTraceT want);
   xlenT     merged;
   netStateT nets;
   logic     nmiTaken;
   want = '0;
   if (mdlSeen && rec.order == mdlLastOrder) begin
      return 1'b0;
   end
   mdlSeen      = 1'b1;
   mdlLastOrder = rec.order;

   want.order   = rec.order;
   want.insn    = rec.insn;
   want.pcRdata = rec.pcRdata;
   want.pcWdata = rec.pcWdata;
   want.mode    = rec.mode;
   want.intr    = rec.intr;
   want.trapExt = rec.trap && (rec.trapCause == ExcInstrBusFault);

   // One bit per GPR, x0 never gets one
   for (int r = 1; r < 32; r++) begin
      want.xWb[r] = (rec.rdAddr == regAddrT'(r));
   end
   want.xWdata = rec.rdWdata;

   // Masked bits take write data, the others keep read data
   for (int c = 0; c < NumCsrs; c++) begin
      for (int b = 0; b < 32; b++) begin
         merged[b] = rec.csr[c].wmask[b] ? rec.csr[c].wdata[b] : rec.csr[c].rdata[b];
      end
      want.csrValue[c] = merged;
      want.csrWb[c]    = (merged != mdlCsr[c]);
      mdlCsr[c]        = merged;
   end

   nmiTaken = rec.intr && rec.intrInterrupt &&
              (rec.intrCause == NmiLoadCause || rec.intrCause == NmiStoreCause);
   nets.nmi         = nmiTaken || rec.nmip[0];
   nets.nmiCause    = nets.nmi ? rec.intrCause : mdlNets.nmiCause;
   nets.insBusFault = rec.trap && rec.trapException && (rec.trapCause == ExcInstrBusFault);
   nets.haltReq     = rec.dbgMode && (rec.dbg == DbgCauseHaltReq);

   want.nets       = nets;
   want.netChanged = {nets.nmi != mdlNets.nmi, nets.nmiCause != mdlNets.nmiCause,
                      nets.insBusFault != mdlNets.insBusFault,
                      nets.haltReq != mdlNets.haltReq};
   mdlNets = nets;
   return 1'b1;
endfunction

`endif

// ==== tbRvviTracer.sv ====
// Testbench for the retirement-trace converter with random stimulus,
// output stalls, a reference model and an output checker
`timescale 1ns/1ns
`default_nettype none

module tbRvviTracer;
   import rvviPkg::*;

   localparam int ClkPeriod    = 100;
   localparam int ResetCycles  = 4;
   localparam int NumGpr       = 40;
   localparam int NumCsrTest   = 60;
   localparam int NumRepeat    = 20;
   localparam int NumNmi       = 40;
   localparam int NumTrap      = 40;
   localparam int NumStall     = 80;
   // The repeat test sends up to three records per step, the stall test runs twice
   localparam int TotalRecords = NumGpr + NumCsrTest + 3 * NumRepeat + NumNmi + NumTrap +
                                 2 * NumStall;

   logic       rvvi;
   logic       rst;
   rvfiRetireT retire;
   logic       retireValid;
   wire        retireReady;
   rvviTraceT  trace;
   wire        traceValid;
   logic       traceReady;

   // Stimulus knobs
   int    stallPct;
   int    maxGap;
   orderT nextOrder;

   // Expected records and the cycle each one was accepted in
   rvviTraceT expQ[$];
   int        accQ[$];
   rvviTraceT wantRec;
   int        accCycle;
   logic      expReady;
   int        cycle     = 0;
   int        lastStall = -1;
   int        errCount  = 0;
   int        inCount   = 0;
   int        outCount  = 0;
   int        dropCount = 0;
   int        testCount = 0;
   int        testFails = 0;

   `include "tbRvviModel.svh"

   rvviTracer u_dut (
      .rvvi          (rvvi),
      .rst_i         (rst),
      .retire_i      (retire),
      .retireValid_i (retireValid),
      .retireReady_o (retireReady),
      .trace_o       (trace),
      .traceValid_o  (traceValid),
      .traceReady_i  (traceReady)
   );

   always #(ClkPeriod / 2) rvvi = ~rvvi;

   // Random output stalls
   always @(posedge rvvi) begin
      traceReady <= (int'($urandom % 100) >= stallPct);
   end

   ////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////
   // Small value pool so the merged CSR value often repeats
   function automatic csrAccessT randomCsr();
      csrAccessT a;
      a.rdata = ($urandom % 2 != 0) ? 32'hA5A5_0F0F : xlenT'($urandom % 4);
      a.wdata = ($urandom % 2 != 0) ? 32'h0000_1800 : xlenT'($urandom);
      case ($urandom % 4)
         0, 1: a.wmask = '0;
         2: a.wmask = '1;
         default: a.wmask = xlenT'($urandom);
      endcase
      return a;
   endfunction

   // Plain retirement with a fresh order and no events
   function automatic rvfiRetireT makeRecord();
      rvfiRetireT rec;
      rec         = '0;
      rec.order   = nextOrder;
      nextOrder   = nextOrder + orderT'(1);
      rec.insn    = xlenT'($urandom);
      rec.pcRdata = xlenT'($urandom);
      rec.pcWdata = xlenT'($urandom);
      rec.mode    = 2'($urandom);
      rec.rdAddr  = regAddrT'($urandom);
      rec.rdWdata = xlenT'($urandom);
      for (int c = 0; c < NumCsrs; c++) begin
         rec.csr[c] = randomCsr();
      end
      return rec;
   endfunction

   task automatic sendRecord(input rvfiRetireT rec);
      int gap;
      gap = int'($urandom % (maxGap + 1));
      repeat (gap) @(posedge rvvi);
      retire      <= rec;
      retireValid <= 1'b1;
      do @(posedge rvvi); while (!retireReady);
      retireValid <= 1'b0;
   endtask

   task automatic reportMismatch(input string name, input logic [127:0] want,
                                 input logic [127:0] got);
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, want, got);
      errCount++;
   endtask

   task automatic checkTrace(input rvviTraceT want, input rvviTraceT got);
      if (got.order !== want.order)
         reportMismatch("order", 128'(want.order), 128'(got.order));
      if (got.insn !== want.insn)
         reportMismatch("insn", 128'(want.insn), 128'(got.insn));
      if (got.pcRdata !== want.pcRdata)
         reportMismatch("pcRdata", 128'(want.pcRdata), 128'(got.pcRdata));
      if (got.pcWdata !== want.pcWdata)
         reportMismatch("pcWdata", 128'(want.pcWdata), 128'(got.pcWdata));
      if (got.mode !== want.mode)
         reportMismatch("mode", 128'(want.mode), 128'(got.mode));
      if (got.trapExt !== want.trapExt)
         reportMismatch("trapExt", 128'(want.trapExt), 128'(got.trapExt));
      if (got.intr !== want.intr)
         reportMismatch("intr", 128'(want.intr), 128'(got.intr));
      if (got.xWb !== want.xWb)
         reportMismatch("xWb", 128'(want.xWb), 128'(got.xWb));
      if (got.xWdata !== want.xWdata)
         reportMismatch("xWdata", 128'(want.xWdata), 128'(got.xWdata));
      if (got.csrValue !== want.csrValue)
         reportMismatch("csrValue", 128'(want.csrValue), 128'(got.csrValue));
      if (got.csrWb !== want.csrWb)
         reportMismatch("csrWb", 128'(want.csrWb), 128'(got.csrWb));
      if (got.nets !== want.nets)
         reportMismatch("nets", 128'(want.nets), 128'(got.nets));
      if (got.netChanged !== want.netChanged)
         reportMismatch("netChanged", 128'(want.netChanged), 128'(got.netChanged));
   endtask

   // Drain the pipeline, then an idle tail to catch stray outputs
   task automatic finishTest(input string name, input int errBefore);
      int waited;
      waited = 0;
      @(posedge rvvi);
      while (expQ.size() != 0 && waited < 200) begin
         @(posedge rvvi);
         waited++;
      end
      if (expQ.size() != 0) begin
         $display("%0d expected records never came out of the DUT", expQ.size());
         errCount++;
         expQ.delete();
         accQ.delete();
      end
      repeat (8) @(posedge rvvi);
      testCount++;
      if (errCount != errBefore) begin
         testFails++;
      end
      $display("Test %s done, %0d errors", name, errCount - errBefore);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Reference and compare
   ////////////////////////////////////////////////////////////////////
   always @(posedge rvvi) begin
      if (rst) begin
         clearModel();
         expQ.delete();
         accQ.delete();
      end else begin
         // Input stalls only with all three stage registers full and the output stalled
         expReady = (expQ.size() < 3) || traceReady;
         if (retireReady !== expReady) begin
            $display("FAILED at %0t: retireReady expected %0b, got %0b", $time,
                     expReady, retireReady);
            errCount++;
         end
         if (traceValid && traceReady) begin
            outCount++;
            if (expQ.size() == 0) begin
               $display("Trace with order %0h came out with no record expected", trace.order);
               errCount++;
            end else begin
               wantRec  = expQ.pop_front();
               accCycle = accQ.pop_front();
               checkTrace(wantRec, trace);
               // Stall-free path since acceptance must take exactly 3 cycles
               if (lastStall <= accCycle && cycle - accCycle != 3) begin
                  $display("FAILED at %0t: latency expected 3, got %0d", $time,
                           cycle - accCycle);
                  errCount++;
               end
            end
         end
         if (!traceReady) begin
            lastStall = cycle;
         end
         if (retireValid && retireReady) begin
            inCount++;
            if (predictTrace(retire, wantRec)) begin
               expQ.push_back(wantRec);
               accQ.push_back(cycle);
            end else begin
               dropCount++;
            end
         end
      end
      cycle++;
   end

   initial begin
      #((TotalRecords * 20 + ResetCycles) * ClkPeriod);
      $display("Timeout, the tests did not finish in the allowed time");
      $display("Regression failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////
   initial begin
      int                      errBefore;
      int                      pick;
      rvfiRetireT              rec;
      rvfiRetireT              dup;
      csrAccessT [NumCsrs-1:0] prevCsr;
      void'($urandom(32'h3561));
      rvvi        = 1'b0;
      rst         = 1'b1;
      retire      = '0;
      retireValid = 1'b0;
      traceReady  = 1'b0;
      stallPct    = 25;
      maxGap      = 2;
      // First order equals the stored order after reset
      nextOrder   = '0;
      prevCsr     = '0;
      repeat (ResetCycles) @(posedge rvvi);
      rst <= 1'b0;

      errBefore = errCount;
      for (int i = 0; i < NumGpr; i++) begin
         rec = makeRecord();
         // Both ends of the register file
         if (i == 0) rec.rdAddr = '0;
         if (i == 1) rec.rdAddr = 5'd31;
         sendRecord(rec);
      end
      finishTest("gpr writeback", errBefore);

      errBefore = errCount;
      for (int i = 0; i < NumCsrTest; i++) begin
         rec = makeRecord();
         // Resend the last accesses now and then so nothing changes
         if (i % 5 == 4) rec.csr = prevCsr;
         prevCsr = rec.csr;
         sendRecord(rec);
      end
      finishTest("csr merge", errBefore);

      errBefore = errCount;
      for (int i = 0; i < NumRepeat; i++) begin
         rec = makeRecord();
         sendRecord(rec);
         dup       = makeRecord();
         dup.order = rec.order;
         sendRecord(dup);
         if (i % 2 == 0) sendRecord(dup);
      end
      finishTest("repeated order", errBefore);

      errBefore = errCount;
      for (int i = 0; i < NumNmi; i++) begin
         rec  = makeRecord();
         pick = int'($urandom % 5);
         case (pick)
            0: begin
               rec.intr          = 1'b1;
               rec.intrInterrupt = 1'b1;
               rec.intrCause     = NmiLoadCause;
            end
            1: begin
               rec.intr          = 1'b1;
               rec.intrInterrupt = 1'b1;
               rec.intrCause     = NmiStoreCause;
            end
            2: begin
               rec.nmip      = 2'($urandom);
               rec.intrCause = causeT'($urandom);
            end
            3: begin
               // Ordinary interrupt, not an NMI
               rec.intr          = 1'b1;
               rec.intrInterrupt = 1'b1;
               rec.intrCause     = causeT'($urandom % 16);
            end
            default: ;
         endcase
         sendRecord(rec);
      end
      finishTest("nmi", errBefore);

      errBefore = errCount;
      for (int i = 0; i < NumTrap; i++) begin
         rec = makeRecord();
         if ($urandom % 2 != 0) begin
            rec.trap          = 1'b1;
            rec.trapException = ($urandom % 4 != 0);
            rec.trapCause     = ($urandom % 2 != 0) ? ExcInstrBusFault : excCauseT'($urandom);
         end
         if ($urandom % 2 != 0) begin
            rec.dbg     = ($urandom % 2 != 0) ? DbgCauseHaltReq : 3'($urandom);
            rec.dbgMode = ($urandom % 4 != 0);
         end
         sendRecord(rec);
      end
      finishTest("bus fault and halt", errBefore);

      // Back-to-back input against heavy output stalls
      errBefore = errCount;
      stallPct  = 50;
      maxGap    = 0;
      for (int i = 0; i < NumStall; i++) begin
         sendRecord(makeRecord());
      end
      finishTest("back-pressure", errBefore);

      errBefore = errCount;
      stallPct  = 0;
      maxGap    = 3;
      for (int i = 0; i < NumStall; i++) begin
         sendRecord(makeRecord());
      end
      finishTest("latency", errBefore);

      $display("Summary: %0d tests, %0d failed, %0d in, %0d out, %0d dropped, %0d errors",
               testCount, testFails, inCount, outCount, dropCount, errCount);
      if (errCount == 0 && testFails == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== rvviTracer.sv ====
// Top level of the retirement-trace converter, filter, writeback decode
// and net tracker stages in a chain
`timescale 1ns/1ns
`default_nettype none

module rvviTracer (
   input  wire                      rvvi,
   input  wire                      rst_i,
   input  wire rvviPkg::rvfiRetireT retire_i,
   input  wire                      retireValid_i,
   output wire                      retireReady_o,
   output rvviPkg::rvviTraceT       trace_o,
   output wire                      traceValid_o,
   input  wire                      traceReady_i
);
   import rvviPkg::*;

   // Filter to writeback decode
   rvfiRetireT filtered;
   logic       filteredValid;
   logic       filteredReady;

   // Writeback decode to net tracker
   decodedRecT decoded;
   logic       decodedValid;
   logic       decodedReady;

   retireFilter u_retireFilter (
      .rvvi          (rvvi),
      .rst_i         (rst_i),
      .retire_i      (retire_i),
      .retireValid_i (retireValid_i),
      .retireReady_o (retireReady_o),
      .retire_o      (filtered),
      .retireValid_o (filteredValid),
      .retireReady_i (filteredReady)
   );

   writebackDecode u_writebackDecode (
      .rvvi          (rvvi),
      .rst_i         (rst_i),
      .retire_i      (filtered),
      .retireValid_i (filteredValid),
      .retireReady_o (filteredReady),
      .dec_o         (decoded),
      .decValid_o    (decodedValid),
      .decReady_i    (decodedReady)
   );

   netEventTracker u_netEventTracker (
      .rvvi         (rvvi),
      .rst_i        (rst_i),
      .dec_i        (decoded),
      .decValid_i   (decodedValid),
      .decReady_o   (decodedReady),
      .trace_o      (trace_o),
      .traceValid_o (traceValid_o),
      .traceReady_i (traceReady_i)
   );

endmodule

`default_nettype wire

// ==== netEventTracker.sv ====
// Third pipeline stage, NMI, instruction bus fault and halt request
// net levels with change flags, plus the external trap flag
`timescale 1ns/1ns
`default_nettype none

module netEventTracker (
   input  wire                      rvvi,
   input  wire                      rst_i,
   input  wire rvviPkg::decodedRecT dec_i,
   input  wire                      decValid_i,
   output logic                     decReady_o,
   output rvviPkg::rvviTraceT       trace_o,
   output logic                     traceValid_o,
   input  wire                      traceReady_i
);
   import rvviPkg::*;

   netStateT   netState;
   netStateT   nextNets;
   logic [3:0] changed;
   logic       nmiCauseHit;
   logic       busFaultCause;
   logic       accept;

   assign decReady_o = !traceValid_o || traceReady_i;
   assign accept     = decValid_i && decReady_o;

   ////////////////////////////////////////////////////////////////////
   // Next net levels
   ////////////////////////////////////////////////////////////////////
   assign nmiCauseHit   = (dec_i.intrCause == NmiLoadCause) ||
                          (dec_i.intrCause == NmiStoreCause);
   assign busFaultCause = (dec_i.trapCause == ExcInstrBusFault);

   always_comb begin
      // Load/store NMI, either taken as an interrupt or still pending
      nextNets.nmi = (dec_i.intr && dec_i.intrInterrupt && nmiCauseHit) || dec_i.nmip[0];

      // Cause holds its last value once nmi drops
      nextNets.nmiCause = nextNets.nmi ? dec_i.intrCause : netState.nmiCause;

      // Fetch fault is reported by the core as a trap, not by the model
      nextNets.insBusFault = dec_i.trap && dec_i.trapException && busFaultCause;

      nextNets.haltReq = (dec_i.dbg == DbgCauseHaltReq) && dec_i.dbgMode;
   end

   // Bit order nmi, nmiCause, insBusFault, haltReq from msb down
   assign changed = {
      nextNets.nmi         != netState.nmi,
      nextNets.nmiCause    != netState.nmiCause,
      nextNets.insBusFault != netState.insBusFault,
      nextNets.haltReq     != netState.haltReq
   };

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         netState <= '0;
      end else if (accept) begin
         netState <= nextNets;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Stage register
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         traceValid_o <= 1'b0;
      end else if (decReady_o) begin
         traceValid_o <= decValid_i;
      end
   end

   always_ff @(posedge rvvi) begin
      if (accept) begin
         trace_o.order      <= dec_i.order;
         trace_o.insn       <= dec_i.insn;
         trace_o.pcRdata    <= dec_i.pcRdata;
         trace_o.pcWdata    <= dec_i.pcWdata;
         trace_o.mode       <= dec_i.mode;
         // Only the cause 48 trap is generated outside the model
         trace_o.trapExt    <= dec_i.trap && busFaultCause;
         trace_o.intr       <= dec_i.intr;
         trace_o.xWb        <= dec_i.xWb;
         trace_o.xWdata     <= dec_i.xWdata;
         trace_o.csrValue   <= dec_i.csrValue;
         trace_o.csrWb      <= dec_i.csrWb;
         trace_o.nets       <= nextNets;
         trace_o.netChanged <= changed;
      end
   end

endmodule

`default_nettype wire

// ==== writebackDecode.sv ====
// Second pipeline stage, GPR writeback mask and merged CSR values
// with per-CSR change flags
`timescale 1ns/1ns
`default_nettype none

module writebackDecode (
   input  wire                      rvvi,
   input  wire                      rst_i,
   input  wire rvviPkg::rvfiRetireT retire_i,
   input  wire                      retireValid_i,
   output logic                     retireReady_o,
   output rvviPkg::decodedRecT      dec_o,
   output logic                     decValid_o,
   input  wire                      decReady_i
);
   import rvviPkg::*;

   xlenT [NumCsrs-1:0] lastCsr;
   xlenT [NumCsrs-1:0] merged;
   csrMaskT            csrChanged;
   regMaskT            gprMask;
   logic               accept;

   assign retireReady_o = !decValid_o || decReady_i;
   assign accept        = retireValid_i && retireReady_o;

   // x0 is never written back
   assign gprMask = (retire_i.rdAddr == '0) ? '0 : (regMaskT'(1) << retire_i.rdAddr);

   ////////////////////////////////////////////////////////////////////
   // CSR merge
   ////////////////////////////////////////////////////////////////////
   // Written bits come from wdata, the rest keep the read value
   always_comb begin
      for (int i = 0; i < NumCsrs; i++) begin
         merged[i] = (retire_i.csr[i].wdata & retire_i.csr[i].wmask) |
                     (retire_i.csr[i].rdata & ~retire_i.csr[i].wmask);
         csrChanged[i] = (merged[i] != lastCsr[i]);
      end
   end

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         lastCsr <= '0;
      end else if (accept) begin
         lastCsr <= merged;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Stage register
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         decValid_o <= 1'b0;
      end else if (retireReady_o) begin
         decValid_o <= retireValid_i;
      end
   end

   always_ff @(posedge rvvi) begin
      if (accept) begin
         dec_o.order         <= retire_i.order;
         dec_o.insn          <= retire_i.insn;
         dec_o.pcRdata       <= retire_i.pcRdata;
         dec_o.pcWdata       <= retire_i.pcWdata;
         dec_o.mode          <= retire_i.mode;
         dec_o.trap          <= retire_i.trap;
         dec_o.trapException <= retire_i.trapException;
         dec_o.trapCause     <= retire_i.trapCause;
         dec_o.intr          <= retire_i.intr;
         dec_o.intrInterrupt <= retire_i.intrInterrupt;
         dec_o.intrCause     <= retire_i.intrCause;
         dec_o.nmip          <= retire_i.nmip;
         dec_o.dbg           <= retire_i.dbg;
         dec_o.dbgMode       <= retire_i.dbgMode;
         dec_o.xWb           <= gprMask;
         dec_o.xWdata        <= retire_i.rdWdata;
         dec_o.csrValue      <= merged;
         dec_o.csrWb         <= csrChanged;
      end
   end

endmodule

`default_nettype wire

// ==== retireFilter.sv ====
// First pipeline stage, accepts retirements and drops repeated order numbers
`timescale 1ns/1ns
`default_nettype none

module retireFilter (
   input  wire                      rvvi,
   input  wire                      rst_i,
   input  wire rvviPkg::rvfiRetireT retire_i,
   input  wire                      retireValid_i,
   output logic                     retireReady_o,
   output rvviPkg::rvfiRetireT      retire_o,
   output logic                     retireValid_o,
   input  wire                      retireReady_i
);
   import rvviPkg::*;

   orderT lastOrder;
   logic  seen;
   logic  accept;
   logic  repeated;

   // Output register empty or being drained this cycle
   assign retireReady_o = !retireValid_o || retireReady_i;
   assign accept        = retireValid_i && retireReady_o;

   // Same order as the last forwarded record means a replayed retirement
   assign repeated = seen && (retire_i.order == lastOrder);

   ////////////////////////////////////////////////////////////////////
   // Stage register
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         retireValid_o <= 1'b0;
      end else if (retireReady_o) begin
         retireValid_o <= retireValid_i && !repeated;
      end
   end

   always_ff @(posedge rvvi) begin
      if (accept && !repeated) begin
         retire_o <= retire_i;
      end
   end

   // Order tracking follows forwarded records only
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         lastOrder <= '0;
         seen      <= 1'b0;
      end else if (accept && !repeated) begin
         lastOrder <= retire_i.order;
         seen      <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rvviPkg.sv ====
// Shared widths, tracked CSR addresses, cause codes and record types
// for the retirement-trace converter
`default_nettype none

package rvviPkg;

   ////////////////////////////////////////////////////////////////////
   // Widths with a meaning
   ////////////////////////////////////////////////////////////////////
   typedef logic [63:0] orderT;
   typedef logic [31:0] xlenT;
   typedef logic [4:0]  regAddrT;
   typedef logic [31:0] regMaskT;
   typedef logic [1:0]  csrIdxT;
   typedef logic [3:0]  csrMaskT;
   typedef logic [10:0] causeT;
   typedef logic [5:0]  excCauseT;

   localparam int NumCsrs = 4;

   // Tracked CSRs, in csr array order
   localparam logic [11:0] CsrMstatusAddr = 12'h300;
   localparam logic [11:0] CsrMepcAddr    = 12'h341;
   localparam logic [11:0] CsrMcauseAddr  = 12'h342;
   localparam logic [11:0] CsrMtvalAddr   = 12'h343;

   // Cause codes seen on the retirement stream
   localparam excCauseT ExcInstrBusFault = 6'd48;
   localparam causeT    NmiLoadCause     = 11'd1024;
   localparam causeT    NmiStoreCause    = 11'd1025;
   localparam logic [2:0] DbgCauseHaltReq = 3'd3;

   ////////////////////////////////////////////////////////////////////
   // Records
   ////////////////////////////////////////////////////////////////////
   typedef struct packed {
      xlenT rdata;
      xlenT wdata;
      xlenT wmask;
   } csrAccessT;

   // One RVFI retirement
   typedef struct packed {
      orderT                   order;
      xlenT                    insn;
      xlenT                    pcRdata;
      xlenT                    pcWdata;
      logic                    trap;
      logic                    trapException;
      excCauseT                trapCause;
      logic                    intr;
      logic                    intrInterrupt;
      causeT                   intrCause;
      logic [1:0]              nmip;
      logic [2:0]              dbg;
      logic                    dbgMode;
      logic [1:0]              mode;
      regAddrT                 rdAddr;
      xlenT                    rdWdata;
      csrAccessT [NumCsrs-1:0] csr;
   } rvfiRetireT;

   // Writeback stage result, still carrying the raw event fields
   typedef struct packed {
      orderT              order;
      xlenT               insn;
      xlenT               pcRdata;
      xlenT               pcWdata;
      logic [1:0]         mode;
      logic               trap;
      logic               trapException;
      excCauseT           trapCause;
      logic               intr;
      logic               intrInterrupt;
      causeT              intrCause;
      logic [1:0]         nmip;
      logic [2:0]         dbg;
      logic               dbgMode;
      regMaskT            xWb;
      xlenT               xWdata;
      xlenT [NumCsrs-1:0] csrValue;
      csrMaskT            csrWb;
   } decodedRecT;

   typedef struct packed {
      logic  nmi;
      causeT nmiCause;
      logic  insBusFault;
      logic  haltReq;
   } netStateT;

   // Output trace record
   typedef struct packed {
      orderT              order;
      xlenT               insn;
      xlenT               pcRdata;
      xlenT               pcWdata;
      logic [1:0]         mode;
      logic               trapExt;
      logic               intr;
      regMaskT            xWb;
      xlenT               xWdata;
      xlenT [NumCsrs-1:0] csrValue;
      csrMaskT            csrWb;
      netStateT           nets;
      logic [3:0]         netChanged;
   } rvviTraceT;

endpackage

`default_nettype wire
